// File: list.f
verilog/video_pkg.sv
verilog/coef_pkg.sv
verilog/chroma_upsampler.sv
verilog/upsample_front.sv
verilog/csc_datapath.sv
verilog/rgb_clipper.sv
verilog/yuv_rgb_top.sv
tb/tb_yuv_rgb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status is the simulation result
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_yuv_rgb -f list.f &&
./obj_dir/Vtb_yuv_rgb || {
	echo "simulation run reported an error"
	exit 1
}

// File: tb/tb_yuv_rgb.sv
// Rows of 8 pixel pairs, one pair every 2 cycles and one row at a time; expected values come from a software model
`timescale 1ns/1ps
`default_nettype none

module tb_yuv_rgb
	import video_pkg::*;
	import coef_pkg::*;
();

localparam int row_pairs = 8;
localparam int row_pixels = 2 * row_pairs;
localparam int num_entries = 12;
localparam int wait_limit = 64;   // Cycles per wait
localparam int idle_cycles = 4;   // Quiet cycles checked after each row
localparam int kind_uniform = 0;
localparam int kind_ramp = 1;
localparam int kind_random = 2;

logic CLOCK_50_I = 1'b0;
logic resetn;
logic pair_valid;
sample_t pair_y_even;
sample_t pair_y_odd;
sample_t pair_u;
sample_t pair_v;
logic rgb_valid;
sample_t rgb_r;
sample_t rgb_g;
sample_t rgb_b;
logic row_done;

string tab_name [num_entries];
int tab_kind [num_entries];
int tab_y [num_entries];
int tab_u [num_entries];
int tab_v [num_entries];
int tab_r [num_entries];   // Expected colour of uniform rows
int tab_g [num_entries];
int tab_b [num_entries];

int row_y_even [row_pairs];
int row_y_odd [row_pairs];
int row_u [row_pairs];
int row_v [row_pairs];
int exp_r [row_pixels];
int exp_g [row_pixels];
int exp_b [row_pixels];

yuv_rgb_top #(
	.row_pairs (row_pairs)
) i_dut (
	.CLOCK_50_I (CLOCK_50_I),
	.resetn (resetn),
	.pair_valid (pair_valid),
	.pair_y_even (pair_y_even),
	.pair_y_odd (pair_y_odd),
	.pair_u (pair_u),
	.pair_v (pair_v),
	.rgb_valid (rgb_valid),
	.rgb_r (rgb_r),
	.rgb_g (rgb_g),
	.rgb_b (rgb_b),
	.row_done (row_done)
);

always #50 CLOCK_50_I = ~CLOCK_50_I;   // 100 ns period

task automatic stop_run(input string why);
	$display("Test failed");
	$fatal(1, "%s", why);
endtask

task automatic check_value(input string test, input string what, input int expected,
	input int actual);
	if (expected != actual) begin
		$display("ERR %s (%s) expected %0d, got %0d", test, what, expected, actual);
		stop_run("output value differs from the reference");
	end
endtask

task automatic set_entry(input int idx, input string name, input int kind, input int y,
	input int u, input int v, input int r, input int g, input int b);
	tab_name[idx] = name;
	tab_kind[idx] = kind;
	tab_y[idx] = y;
	tab_u[idx] = u;
	tab_v[idx] = v;
	tab_r[idx] = r;
	tab_g[idx] = g;
	tab_b[idx] = b;
endtask

task automatic load_table();
	set_entry(0, "black", kind_uniform, 16, 128, 128, 0, 0, 0);
	set_entry(1, "mid_gray", kind_uniform, 126, 128, 128, 128, 128, 128);
	set_entry(2, "high_v", kind_uniform, 235, 128, 240, 255, 163, 254);   // Red clips high
	set_entry(3, "high_u", kind_uniform, 235, 240, 128, 254, 211, 255);   // Blue clips high
	set_entry(4, "low_u", kind_uniform, 16, 16, 128, 0, 43, 0);   // Blue clips low
	set_entry(5, "low_v", kind_uniform, 16, 128, 16, 0, 91, 0);   // Red clips low
	set_entry(6, "high_g", kind_uniform, 235, 16, 16, 76, 255, 28);   // Green clips high
	set_entry(7, "low_g", kind_uniform, 16, 240, 240, 178, 0, 226);   // Green clips low
	set_entry(8, "chroma_ramp", kind_ramp, 40, 30, 90, 0, 0, 0);
	set_entry(9, "random_a", kind_random, 0, 0, 0, 0, 0, 0);
	set_entry(10, "random_b", kind_random, 0, 0, 0, 0, 0, 0);
	set_entry(11, "random_c", kind_random, 0, 0, 0, 0, 0, 0);
endtask

function automatic int clamp_byte(input int value);
	if (value < 0) begin
		return 0;
	end else if (value > 255) begin
		return 255;
	end
	return value;
endfunction

// Chroma sample with the row edges repeated
function automatic int edge_sample(input int chan, input int idx);
	int k;
	k = idx;
	if (k < 0) begin
		k = 0;
	end
	if (k > row_pairs - 1) begin
		k = row_pairs - 1;
	end
	return (chan == 0) ? row_u[k] : row_v[k];
endfunction

// Odd pixel chroma, halfway between pair j and pair j+1
function automatic int odd_chroma(input int chan, input int j);
	int acc;
	acc = int'(tap_outer) * (edge_sample(chan, j - 2) + edge_sample(chan, j + 3));
	acc = acc - int'(tap_middle) * (edge_sample(chan, j - 1) + edge_sample(chan, j + 2));
	acc = acc + int'(tap_inner) * (edge_sample(chan, j) + edge_sample(chan, j + 1));
	return clamp_byte((acc + int'(filter_round)) >>> filter_shift);
endfunction

function automatic int scale_clip(input int sum);
	return clamp_byte(sum >>> csc_shift);
endfunction

task automatic convert_pixel(input int idx, input int y, input int u, input int v);
	int y_term;
	int u_off;
	int v_off;
	y_term = int'(csc_y) * (y - int'(luma_offset));
	u_off = u - int'(chroma_offset);
	v_off = v - int'(chroma_offset);
	exp_r[idx] = scale_clip(y_term + int'(csc_rv) * v_off);
	exp_g[idx] = scale_clip(y_term - int'(csc_gu) * u_off - int'(csc_gv) * v_off);
	exp_b[idx] = scale_clip(y_term + int'(csc_bu) * u_off);
endtask

task automatic build_row(input int e);
	for (int k = 0; k < row_pairs; k++) begin
		if (tab_kind[e] == kind_random) begin
			row_y_even[k] = $urandom % 256;
			row_y_odd[k] = $urandom % 256;
			row_u[k] = $urandom % 256;
			row_v[k] = $urandom % 256;
		end else if (tab_kind[e] == kind_ramp) begin
			row_y_even[k] = tab_y[e] + 16 * k;
			row_y_odd[k] = tab_y[e] + 16 * k + 8;
			row_u[k] = tab_u[e] + 20 * k;   // Chroma steps of 20 per pair
			row_v[k] = tab_v[e] + 20 * k;
		end else begin
			row_y_even[k] = tab_y[e];
			row_y_odd[k] = tab_y[e];
			row_u[k] = tab_u[e];
			row_v[k] = tab_v[e];
		end
	end
endtask

task automatic build_expected(input int e);
	for (int j = 0; j < row_pairs; j++) begin
		if (tab_kind[e] == kind_uniform) begin
			exp_r[2 * j] = tab_r[e];
			exp_g[2 * j] = tab_g[e];
			exp_b[2 * j] = tab_b[e];
			exp_r[2 * j + 1] = tab_r[e];
			exp_g[2 * j + 1] = tab_g[e];
			exp_b[2 * j + 1] = tab_b[e];
		end else begin
			convert_pixel(2 * j, row_y_even[j], row_u[j], row_v[j]);
			convert_pixel(2 * j + 1, row_y_odd[j], odd_chroma(0, j), odd_chroma(1, j));
		end
	end
endtask

task automatic drive_row();
	for (int k = 0; k < row_pairs; k++) begin
		@(posedge CLOCK_50_I);
		pair_valid <= 1'b1;
		pair_y_even <= sample_t'(row_y_even[k]);
		pair_y_odd <= sample_t'(row_y_odd[k]);
		pair_u <= sample_t'(row_u[k]);
		pair_v <= sample_t'(row_v[k]);
		@(posedge CLOCK_50_I);
		pair_valid <= 1'b0;   // Keeps strobes 2 cycles apart
	end
endtask

task automatic collect_row(input int e);
	int pix;
	int waited;
	pix = 0;
	while (pix < row_pixels) begin
		waited = 0;
		@(negedge CLOCK_50_I);
		while (!rgb_valid) begin
			check_value(tab_name[e], "row_done without pixel", 0, int'(row_done));
			waited++;
			if (waited > wait_limit) begin
				stop_run($sformatf("pixel %0d of row %s did not arrive within %0d cycles",
					pix, tab_name[e], wait_limit));
			end
			@(negedge CLOCK_50_I);
		end
		check_value(tab_name[e], $sformatf("pixel %0d red", pix), exp_r[pix], int'(rgb_r));
		check_value(tab_name[e], $sformatf("pixel %0d green", pix), exp_g[pix], int'(rgb_g));
		check_value(tab_name[e], $sformatf("pixel %0d blue", pix), exp_b[pix], int'(rgb_b));
		check_value(tab_name[e], $sformatf("pixel %0d row_done", pix),
			(pix == row_pixels - 1) ? 1 : 0, int'(row_done));
		pix++;
	end
	// Pipeline must stay quiet until the next row starts
	repeat (idle_cycles) begin
		@(negedge CLOCK_50_I);
		check_value(tab_name[e], "rgb_valid after row end", 0, int'(rgb_valid));
		check_value(tab_name[e], "row_done after row end", 0, int'(row_done));
	end
endtask

initial begin
	resetn <= 1'b0;
	pair_valid <= 1'b0;
	pair_y_even <= '0;
	pair_y_odd <= '0;
	pair_u <= '0;
	pair_v <= '0;
	void'($urandom(32'h8ed97c71));
	load_table();
	repeat (3) @(posedge CLOCK_50_I);
	resetn <= 1'b1;
	for (int e = 0; e < num_entries; e++) begin
		build_row(e);
		build_expected(e);
		fork
			drive_row();
			collect_row(e);
		join
	end
	$display("Test completed successfully");
	$finish;
end

endmodule

`default_nettype wire

// File: verilog/yuv_rgb_top.sv
// One 4:2:2 row in, RGB pixels out; pairs at least 2 cycles apart, next row only after row_done
`timescale 1ns/1ps
`default_nettype none

module yuv_rgb_top
	import video_pkg::*;
#(
	parameter int row_pairs = 160   // Pixel pairs per row, at least 4
) (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic pair_valid,
	input sample_t pair_y_even,
	input sample_t pair_y_odd,
	input sample_t pair_u,
	input sample_t pair_v,
	output logic rgb_valid,
	output sample_t rgb_r,
	output sample_t rgb_g,
	output sample_t rgb_b,
	output logic row_done
);

logic dec_valid;
logic dec_last;
sample_t dec_y_even;
sample_t dec_y_odd;
sample_t dec_u_even;
sample_t dec_u_odd;
sample_t dec_v_even;
sample_t dec_v_odd;

logic csc_valid;
logic csc_last;
chroma_acc_t csc_r;
chroma_acc_t csc_g;
chroma_acc_t csc_b;

upsample_front #(
	.row_pairs (row_pairs)
) i_front (
	.CLOCK_50_I (CLOCK_50_I),
	.resetn (resetn),
	.pair_valid (pair_valid),
	.pair_y_even (pair_y_even),
	.pair_y_odd (pair_y_odd),
	.pair_u (pair_u),
	.pair_v (pair_v),
	.dec_valid (dec_valid),
	.dec_y_even (dec_y_even),
	.dec_y_odd (dec_y_odd),
	.dec_u_even (dec_u_even),
	.dec_u_odd (dec_u_odd),
	.dec_v_even (dec_v_even),
	.dec_v_odd (dec_v_odd),
	.dec_last (dec_last)
);

csc_datapath i_csc (
	.CLOCK_50_I (CLOCK_50_I),
	.resetn (resetn),
	.dec_valid (dec_valid),
	.dec_y_even (dec_y_even),
	.dec_y_odd (dec_y_odd),
	.dec_u_even (dec_u_even),
	.dec_u_odd (dec_u_odd),
	.dec_v_even (dec_v_even),
	.dec_v_odd (dec_v_odd),
	.dec_last (dec_last),
	.csc_valid (csc_valid),
	.csc_r (csc_r),
	.csc_g (csc_g),
	.csc_b (csc_b),
	.csc_last (csc_last)
);

rgb_clipper i_result (
	.CLOCK_50_I (CLOCK_50_I),
	.resetn (resetn),
	.csc_valid (csc_valid),
	.csc_r (csc_r),
	.csc_g (csc_g),
	.csc_b (csc_b),
	.csc_last (csc_last),
	.rgb_valid (rgb_valid),
	.rgb_r (rgb_r),
	.rgb_g (rgb_g),
	.rgb_b (rgb_b),
	.row_done (row_done)
);

endmodule

`default_nettype wire

// File: verilog/rgb_clipper.sv
// No back-pressure; every rgb_valid strobe must be taken by the sink in its cycle
`timescale 1ns/1ps
`default_nettype none

module rgb_clipper
	import video_pkg::*;
	import coef_pkg::*;
(
	input logic CLOCK_50_I,
	input logic resetn,
	input logic csc_valid,
	input chroma_acc_t csc_r,
	input chroma_acc_t csc_g,
	input chroma_acc_t csc_b,
	input logic csc_last,
	output logic rgb_valid,
	output sample_t rgb_r,
	output sample_t rgb_g,
	output sample_t rgb_b,
	output logic row_done
);

// Drop fraction bits and saturate to one byte
function automatic sample_t clip_color(input chroma_acc_t sum);
	chroma_acc_t scaled;
	scaled = sum >>> csc_shift;
	if (scaled < 0) begin
		return 8'd0;
	end else if (scaled > chroma_acc_t'(255)) begin
		return 8'd255;
	end
	return scaled[7:0];
endfunction

always_ff @(posedge CLOCK_50_I) begin
	if (csc_valid) begin
		rgb_r <= clip_color(csc_r);
		rgb_g <= clip_color(csc_g);
		rgb_b <= clip_color(csc_b);
	end
end

always_ff @(posedge CLOCK_50_I or negedge resetn) begin
	if (!resetn) begin
		rgb_valid <= 1'b0;
		row_done <= 1'b0;
	end else begin
		rgb_valid <= csc_valid;
		row_done <= csc_valid & csc_last;   // With the final pixel
	end
end

endmodule

`default_nettype wire

// File: verilog/csc_datapath.sv
// Decoded pairs must be at least 2 cycles apart; even pixel out after 2 cycles, odd after 3
`timescale 1ns/1ps
`default_nettype none

module csc_datapath
	import video_pkg::*;
	import coef_pkg::*;
(
	input logic CLOCK_50_I,
	input logic resetn,
	input logic dec_valid,
	input sample_t dec_y_even,
	input sample_t dec_y_odd,
	input sample_t dec_u_even,
	input sample_t dec_u_odd,
	input sample_t dec_v_even,
	input sample_t dec_v_odd,
	input logic dec_last,
	output logic csc_valid,
	output chroma_acc_t csc_r,
	output chroma_acc_t csc_g,
	output chroma_acc_t csc_b,
	output logic csc_last
);

sample_t y_in [0:1];   // Index 0 even pixel, 1 odd pixel
sample_t u_in [0:1];
sample_t v_in [0:1];

chroma_acc_t y_op [0:1];
chroma_acc_t u_op [0:1];
chroma_acc_t v_op [0:1];

chroma_acc_t y_prod [0:1];
chroma_acc_t rv_prod [0:1];
chroma_acc_t gu_prod [0:1];
chroma_acc_t gv_prod [0:1];
chroma_acc_t bu_prod [0:1];

chroma_acc_t sum_r [0:1];
chroma_acc_t sum_g [0:1];
chroma_acc_t sum_b [0:1];

chroma_acc_t odd_r;
chroma_acc_t odd_g;
chroma_acc_t odd_b;

logic s1_valid;
logic s1_last;
logic odd_pending;
logic odd_last;

assign y_in[0] = dec_y_even;
assign y_in[1] = dec_y_odd;
assign u_in[0] = dec_u_even;
assign u_in[1] = dec_u_odd;
assign v_in[0] = dec_v_even;
assign v_in[1] = dec_v_odd;

always_comb begin
	for (int p = 0; p < 2; p++) begin
		y_op[p] = chroma_acc_t'(y_in[p]) - chroma_acc_t'(luma_offset);
		u_op[p] = chroma_acc_t'(u_in[p]) - chroma_acc_t'(chroma_offset);
		v_op[p] = chroma_acc_t'(v_in[p]) - chroma_acc_t'(chroma_offset);

		sum_r[p] = y_prod[p] + rv_prod[p];
		sum_g[p] = y_prod[p] - gu_prod[p] - gv_prod[p];
		sum_b[p] = y_prod[p] + bu_prod[p];
	end
end

// Stage one, ten dedicated multipliers
always_ff @(posedge CLOCK_50_I) begin
	if (dec_valid) begin
		for (int p = 0; p < 2; p++) begin
			y_prod[p] <= y_op[p] * chroma_acc_t'(csc_y);
			rv_prod[p] <= v_op[p] * chroma_acc_t'(csc_rv);
			gu_prod[p] <= u_op[p] * chroma_acc_t'(csc_gu);
			gv_prod[p] <= v_op[p] * chroma_acc_t'(csc_gv);
			bu_prod[p] <= u_op[p] * chroma_acc_t'(csc_bu);
		end
	end
end

// Stage two, even pixel first, odd pixel parked for a cycle
always_ff @(posedge CLOCK_50_I) begin
	if (s1_valid) begin
		csc_r <= sum_r[0];
		csc_g <= sum_g[0];
		csc_b <= sum_b[0];
		odd_r <= sum_r[1];
		odd_g <= sum_g[1];
		odd_b <= sum_b[1];
	end else if (odd_pending) begin
		csc_r <= odd_r;
		csc_g <= odd_g;
		csc_b <= odd_b;
	end
end

always_ff @(posedge CLOCK_50_I or negedge resetn) begin
	if (!resetn) begin
		s1_valid <= 1'b0;
		s1_last <= 1'b0;
		odd_pending <= 1'b0;
		odd_last <= 1'b0;
		csc_valid <= 1'b0;
		csc_last <= 1'b0;
	end else begin
		s1_valid <= dec_valid;
		s1_last <= dec_valid & dec_last;
		odd_pending <= s1_valid;
		odd_last <= s1_last;
		csc_valid <= s1_valid | odd_pending;
		csc_last <= odd_pending & odd_last;   // Only with the odd pixel
	end
end

endmodule

`default_nettype wire

// File: verilog/upsample_front.sv
// Pairs must be at least 2 cycles apart and a new row may only start after row_done; row_pairs >= 4
`timescale 1ns/1ps
`default_nettype none

module upsample_front
	import video_pkg::*;
#(
	parameter int row_pairs = 160
) (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic pair_valid,
	input sample_t pair_y_even,
	input sample_t pair_y_odd,
	input sample_t pair_u,
	input sample_t pair_v,
	output logic dec_valid,
	output sample_t dec_y_even,
	output sample_t dec_y_odd,
	output sample_t dec_u_even,
	output sample_t dec_u_odd,
	output sample_t dec_v_even,
	output sample_t dec_v_odd,
	output logic dec_last
);

localparam int cnt_w = $clog2(row_pairs + 4);
localparam logic [cnt_w-1:0] last_pair_cnt = cnt_w'(row_pairs - 1);
localparam logic [cnt_w-1:0] flush_end_cnt = cnt_w'(row_pairs + 2);
localparam logic [cnt_w-1:0] first_out_cnt = cnt_w'(3);

logic [cnt_w-1:0] shift_cnt;   // Shifts done in this row
logic flushing;
logic flush_gap;
logic flush_shift;
logic shift;
logic row_first;
logic out_pending;
logic out_last;

sample_t u_hold;
sample_t v_hold;
sample_t u_sample;
sample_t v_sample;
sample_t y_even_pipe [0:3];
sample_t y_odd_pipe [0:3];

assign flush_shift = flushing & ~flush_gap;
assign shift = pair_valid | flush_shift;
assign row_first = pair_valid && (shift_cnt == '0);

// Tail of the row repeats the last chroma sample
assign u_sample = pair_valid ? pair_u : u_hold;
assign v_sample = pair_valid ? pair_v : v_hold;

always_ff @(posedge CLOCK_50_I or negedge resetn) begin
	if (!resetn) begin
		shift_cnt <= '0;
		flushing <= 1'b0;
		flush_gap <= 1'b0;
		out_pending <= 1'b0;
		out_last <= 1'b0;
		dec_valid <= 1'b0;
		dec_last <= 1'b0;
	end else begin
		if (shift) begin
			if (shift_cnt == flush_end_cnt) begin
				shift_cnt <= '0;
			end else begin
				shift_cnt <= shift_cnt + 1'b1;
			end
		end

		if (pair_valid && (shift_cnt == last_pair_cnt)) begin
			flushing <= 1'b1;   // Start flush after last input pair
			flush_gap <= 1'b1;
		end else if (flushing) begin
			flush_gap <= ~flush_gap;   // Keep flush shifts 2 cycles apart
			if (flush_shift && (shift_cnt == flush_end_cnt)) begin
				flushing <= 1'b0;
			end
		end

		out_pending <= shift && (shift_cnt >= first_out_cnt);
		out_last <= shift && (shift_cnt == flush_end_cnt);
		dec_valid <= out_pending;
		dec_last <= out_last;
	end
end

always_ff @(posedge CLOCK_50_I) begin
	if (pair_valid) begin
		u_hold <= pair_u;
		v_hold <= pair_v;
	end
	if (shift) begin
		y_even_pipe[0] <= pair_y_even;   // Flush entries are never read
		y_odd_pipe[0] <= pair_y_odd;
		for (int i = 1; i < 4; i++) begin
			y_even_pipe[i] <= y_even_pipe[i - 1];
			y_odd_pipe[i] <= y_odd_pipe[i - 1];
		end
	end
	if (out_pending) begin
		dec_y_even <= y_even_pipe[3];   // Aligned with chroma centre
		dec_y_odd <= y_odd_pipe[3];
	end
end

chroma_upsampler i_u_upsampler (
	.CLOCK_50_I (CLOCK_50_I),
	.resetn (resetn),
	.shift (shift),
	.row_first (row_first),
	.sample (u_sample),
	.even_out (dec_u_even),
	.odd_out (dec_u_odd)
);

chroma_upsampler i_v_upsampler (
	.CLOCK_50_I (CLOCK_50_I),
	.resetn (resetn),
	.shift (shift),
	.row_first (row_first),
	.sample (v_sample),
	.even_out (dec_v_even),
	.odd_out (dec_v_odd)
);

endmodule

`default_nettype wire

// File: verilog/chroma_upsampler.sv
// One chroma channel; shift and row_first are single-cycle, outputs are valid from the cycle after the shift is registered
`timescale 1ns/1ps
`default_nettype none

module chroma_upsampler
	import video_pkg::*;
	import coef_pkg::*;
(
	input bit CLOCK_50_I,
	input bit resetn,
	input logic shift,
	input logic row_first,
	input sample_t sample,
	output sample_t even_out,
	output sample_t odd_out
);

sample_t win [0:5];   // Slot 0 oldest, slot 5 newest
logic shift_d;

chroma_acc_t outer_sum;
chroma_acc_t middle_sum;
chroma_acc_t inner_sum;
chroma_acc_t filt_sum;
chroma_acc_t odd_val;

// Symmetric taps, so pair the samples before weighting
assign outer_sum = chroma_acc_t'(win[0]) + chroma_acc_t'(win[5]);
assign middle_sum = chroma_acc_t'(win[1]) + chroma_acc_t'(win[4]);
assign inner_sum = chroma_acc_t'(win[2]) + chroma_acc_t'(win[3]);

assign filt_sum = chroma_acc_t'(tap_outer) * outer_sum
	- chroma_acc_t'(tap_middle) * middle_sum
	+ chroma_acc_t'(tap_inner) * inner_sum
	+ chroma_acc_t'(filter_round);

assign odd_val = filt_sum >>> filter_shift;

always_ff @(posedge CLOCK_50_I) begin
	if (shift) begin
		if (row_first) begin
			for (int i = 0; i < 6; i++) begin
				win[i] <= sample;   // Left edge repeats first sample
			end
		end else begin
			for (int i = 0; i < 5; i++) begin
				win[i] <= win[i + 1];
			end
			win[5] <= sample;
		end
	end
end

always_ff @(posedge CLOCK_50_I or negedge resetn) begin
	if (!resetn) begin
		shift_d <= 1'b0;
	end else begin
		shift_d <= shift;
	end
end

// Outputs follow the window by one cycle
always_ff @(posedge CLOCK_50_I) begin
	if (shift_d) begin
		even_out <= win[2];   // Centre slot, no filtering
		if (odd_val < 0) begin
			odd_out <= 8'd0;
		end else if (odd_val > chroma_acc_t'(255)) begin
			odd_out <= 8'd255;
		end else begin
			odd_out <= odd_val[7:0];
		end
	end
end

endmodule

`default_nettype wire

// File: verilog/coef_pkg.sv
// Fixed-point constants for the 4:2:2 upsampler and the YUV to RGB matrix; matrix has 16 fraction bits
`default_nettype none

package coef_pkg;

	// Six-tap chroma interpolation filter, taps sum to 256
	localparam logic [7:0] tap_outer = 8'd21;
	localparam logic [7:0] tap_middle = 8'd52;   // Subtracted
	localparam logic [7:0] tap_inner = 8'd159;
	localparam logic [7:0] filter_round = 8'd128;   // Half of 256
	localparam int filter_shift = 8;

	// Colour matrix, scaled by 65536
	localparam logic [17:0] csc_y = 18'd76284;
	localparam logic [17:0] csc_rv = 18'd104595;
	localparam logic [17:0] csc_gu = 18'd25624;
	localparam logic [17:0] csc_gv = 18'd53281;
	localparam logic [17:0] csc_bu = 18'd132251;

	// Offsets removed before the matrix
	localparam logic [7:0] luma_offset = 8'd16;
	localparam logic [7:0] chroma_offset = 8'd128;

	localparam int csc_shift = 16;   // Fraction bits of the matrix result

endpackage

`default_nettype wire

// File: verilog/video_pkg.sv
// Samples are unsigned 8-bit bytes; all filter and matrix sums use one signed 32-bit word
`default_nettype none

package video_pkg;

	// One luma, chroma or colour byte
	typedef logic [7:0] sample_t;

	// Signed sum wide enough for the largest matrix product plus headroom
	typedef logic signed [31:0] chroma_acc_t;

endpackage

`default_nettype wire
